//--- logic/ex_pkg.sv
// Execute block shared definitions

package ex_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // Datapath width
  localparam int XLEN = 32;

  // ALU operator code width
  localparam int ALU_OP_WIDTH = 5;

  // Serial iteration counter, must reach XLEN
  localparam int MD_COUNT_W = 6;

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////

  // Operand and result word
  typedef logic [XLEN-1:0] word_t;

  // ALU operators
  typedef enum logic [ALU_OP_WIDTH-1:0] {
    // Arithmetic
    ALU_ADD  = 5'b00000,
    ALU_SUB  = 5'b00001,
    // Bitwise logic
    ALU_XOR  = 5'b00100,
    ALU_OR   = 5'b00101,
    ALU_AND  = 5'b00110,
    // Shifts
    ALU_SLL  = 5'b01000,
    ALU_SRL  = 5'b01001,
    ALU_SRA  = 5'b01010,
    // Set on less than, 0 or 1 in the result
    ALU_SLT  = 5'b01100,
    ALU_SLTU = 5'b01101,
    // Branch compares, all have bit 4 set
    ALU_EQ   = 5'b10000,
    ALU_NE   = 5'b10001,
    ALU_LT   = 5'b10010,
    ALU_GE   = 5'b10011,
    ALU_LTU  = 5'b10100,
    ALU_GEU  = 5'b10101
  } alu_op_e;

  // Multiplier/divider operators
  typedef enum logic [1:0] {
    MD_MUL  = 2'b00,
    MD_MULH = 2'b01,
    MD_DIV  = 2'b10,
    MD_REM  = 2'b11
  } md_op_e;

  // Signed mode
  // bit 0 set when operand a is signed, bit 1 for operand b
  typedef logic [1:0] md_sign_t;

endpackage

//--- logic/ex_op_if.sv
// Issued operation bundle
`timescale 1ns/100ps

interface ex_op_if ();

  // ALU side
  ex_pkg::alu_op_e  alu_operator;

  // Multiplier/divider side
  ex_pkg::md_op_e   md_operator;
  ex_pkg::md_sign_t md_signed_mode;

  // Shared operands
  ex_pkg::word_t    operand_a;
  ex_pkg::word_t    operand_b;

  // Issue register in the block top
  modport issue_mp (
    output alu_operator, md_operator, md_signed_mode, operand_a, operand_b
  );

  // Single cycle ALU
  modport alu_mp (
    input alu_operator, operand_a, operand_b
  );

  // Serial multiplier/divider
  modport md_mp (
    input md_operator, md_signed_mode, operand_a, operand_b
  );

endinterface

//--- logic/ex_alu.sv
// Single cycle ALU
`timescale 1ns/100ps

module ex_alu (
  ex_op_if.alu_mp       op,
  output ex_pkg::word_t result_o,
  output ex_pkg::word_t adder_result_o,
  output logic          branch_decision_o
);

  // Bit order reversal for the left shift
  function automatic ex_pkg::word_t bit_rev(input ex_pkg::word_t v);
    ex_pkg::word_t r;
    for (int i = 0; i < ex_pkg::XLEN; i++) begin
      r[i] = v[ex_pkg::XLEN-1-i];
    end
    return r;
  endfunction

  logic                   is_sub;
  ex_pkg::word_t          b_in;
  logic [ex_pkg::XLEN:0]  adder;
  logic                   carry;
  logic                   eq;
  logic                   lt_u;
  logic                   lt_s;

  logic                   shift_left;
  logic                   shift_arith;
  ex_pkg::word_t          shift_in;
  logic [ex_pkg::XLEN:0]  shift_wide;
  logic [ex_pkg::XLEN:0]  shift_wide_res;
  ex_pkg::word_t          shift_res;

  ////////////////////////////////////////
  // Adder
  ////////////////////////////////////////

  // Subtract for SUB, SLT and all compares
  always_comb begin
    case (op.alu_operator)
      ex_pkg::ALU_SUB, ex_pkg::ALU_SLT, ex_pkg::ALU_SLTU,
      ex_pkg::ALU_EQ, ex_pkg::ALU_NE, ex_pkg::ALU_LT,
      ex_pkg::ALU_GE, ex_pkg::ALU_LTU, ex_pkg::ALU_GEU: is_sub = 1'b1;
      default: is_sub = 1'b0;
    endcase
  end

  // a + ~b + 1 for subtract
  assign b_in  = is_sub ? ~op.operand_b : op.operand_b;
  assign adder = {1'b0, op.operand_a} + {1'b0, b_in} + {{ex_pkg::XLEN{1'b0}}, is_sub};
  assign carry = adder[ex_pkg::XLEN];

  // Also the jump and address target
  assign adder_result_o = adder[ex_pkg::XLEN-1:0];

  ////////////////////////////////////////
  // Comparator
  ////////////////////////////////////////

  assign eq   = (adder[ex_pkg::XLEN-1:0] == '0);
  // No carry out of a - b means a < b unsigned
  assign lt_u = ~carry;
  // Differing signs decide directly, else as unsigned
  assign lt_s = (op.operand_a[ex_pkg::XLEN-1] ^ op.operand_b[ex_pkg::XLEN-1]) ?
                op.operand_a[ex_pkg::XLEN-1] : lt_u;

  always_comb begin
    case (op.alu_operator)
      ex_pkg::ALU_EQ:  branch_decision_o = eq;
      ex_pkg::ALU_NE:  branch_decision_o = ~eq;
      ex_pkg::ALU_LT:  branch_decision_o = lt_s;
      ex_pkg::ALU_GE:  branch_decision_o = ~lt_s;
      ex_pkg::ALU_LTU: branch_decision_o = lt_u;
      ex_pkg::ALU_GEU: branch_decision_o = ~lt_u;
      default:         branch_decision_o = 1'b0;
    endcase
  end

  ////////////////////////////////////////
  // Shifter
  ////////////////////////////////////////

  assign shift_left  = (op.alu_operator == ex_pkg::ALU_SLL);
  assign shift_arith = (op.alu_operator == ex_pkg::ALU_SRA);

  // Left shift is a right shift of the reversed word
  assign shift_in   = shift_left ? bit_rev(op.operand_a) : op.operand_a;
  // Extra top bit carries the sign for SRA
  assign shift_wide = {shift_arith & op.operand_a[ex_pkg::XLEN-1], shift_in};
  assign shift_wide_res = $signed(shift_wide) >>>
                          op.operand_b[$clog2(ex_pkg::XLEN)-1:0];
  assign shift_res  = shift_left ? bit_rev(shift_wide_res[ex_pkg::XLEN-1:0]) :
                      shift_wide_res[ex_pkg::XLEN-1:0];

  ////////////////////////////////////////
  // Result select
  ////////////////////////////////////////

  always_comb begin
    case (op.alu_operator)
      ex_pkg::ALU_ADD, ex_pkg::ALU_SUB: result_o = adder[ex_pkg::XLEN-1:0];
      ex_pkg::ALU_XOR: result_o = op.operand_a ^ op.operand_b;
      ex_pkg::ALU_OR:  result_o = op.operand_a | op.operand_b;
      ex_pkg::ALU_AND: result_o = op.operand_a & op.operand_b;
      ex_pkg::ALU_SLL, ex_pkg::ALU_SRL, ex_pkg::ALU_SRA: result_o = shift_res;
      ex_pkg::ALU_SLT:  result_o = {{(ex_pkg::XLEN-1){1'b0}}, lt_s};
      ex_pkg::ALU_SLTU: result_o = {{(ex_pkg::XLEN-1){1'b0}}, lt_u};
      // Branches return their decision as a word
      default: result_o = {{(ex_pkg::XLEN-1){1'b0}}, branch_decision_o};
    endcase
  end

endmodule

//--- logic/ex_multdiv_slow.sv
// Serial multiplier and divider
`timescale 1ns/100ps

module ex_multdiv_slow (
  input  logic          clk_i,
  input  logic          rst_n_i,
  ex_op_if.md_mp        op,
  input  logic          start_i,
  output logic          done_o,
  output ex_pkg::word_t result_o
);

  typedef enum logic [1:0] {
    MD_IDLE,
    MD_COMPUTE,
    MD_FINISH
  } md_state_e;

  md_state_e                     state_q;
  logic [ex_pkg::MD_COUNT_W-1:0] cnt_q;
  logic [ex_pkg::MD_COUNT_W-1:0] cnt_last;

  // Operand magnitudes at start
  logic                          a_neg;
  logic                          b_neg;
  logic                          start_div;
  ex_pkg::word_t                 a_mag;
  ex_pkg::word_t                 b_mag;

  // Latched operation
  ex_pkg::md_op_e                op_q;
  logic                          is_div;
  logic                          neg_q;
  logic                          neg_rem_q;
  logic [2*ex_pkg::XLEN-1:0]     acc_q;
  ex_pkg::word_t                 opd_q;
  ex_pkg::word_t                 res_q;

  // One iteration step
  logic [ex_pkg::XLEN:0]         mul_sum;
  logic [2*ex_pkg::XLEN-1:0]     mul_next;
  logic [ex_pkg::XLEN:0]         div_shift;
  logic [ex_pkg::XLEN:0]         div_diff;
  logic                          div_ge;
  logic [2*ex_pkg::XLEN-1:0]     div_next;

  ex_pkg::word_t                 quot;
  ex_pkg::word_t                 rem;
  logic [2*ex_pkg::XLEN-1:0]     prod_signed;

  ////////////////////////////////////////
  // Operand preparation
  ////////////////////////////////////////

  assign a_neg     = op.md_signed_mode[0] & op.operand_a[ex_pkg::XLEN-1];
  assign b_neg     = op.md_signed_mode[1] & op.operand_b[ex_pkg::XLEN-1];
  assign a_mag     = a_neg ? (~op.operand_a + 1'b1) : op.operand_a;
  assign b_mag     = b_neg ? (~op.operand_b + 1'b1) : op.operand_b;
  // DIV and REM share the top operator bit
  assign start_div = op.md_operator[1];

  assign is_div    = op_q[1];
  // Divide spends one more cycle on sign fix-up
  assign cnt_last  = is_div ? ex_pkg::MD_COUNT_W'(ex_pkg::XLEN) :
                     ex_pkg::MD_COUNT_W'(ex_pkg::XLEN - 1);

  ////////////////////////////////////////
  // Datapath step
  ////////////////////////////////////////

  // Shift-add, multiplier bits leave at the bottom of acc
  assign mul_sum  = acc_q[0] ? {1'b0, acc_q[2*ex_pkg::XLEN-1:ex_pkg::XLEN]} + {1'b0, opd_q} :
                    {1'b0, acc_q[2*ex_pkg::XLEN-1:ex_pkg::XLEN]};
  assign mul_next = {mul_sum, acc_q[ex_pkg::XLEN-1:1]};

  // Restoring step, remainder on top and quotient shifting in below
  assign div_shift = {acc_q[2*ex_pkg::XLEN-1:ex_pkg::XLEN], acc_q[ex_pkg::XLEN-1]};
  assign div_diff  = div_shift - {1'b0, opd_q};
  assign div_ge    = ~div_diff[ex_pkg::XLEN];
  assign div_next  = {div_ge ? div_diff[ex_pkg::XLEN-1:0] : div_shift[ex_pkg::XLEN-1:0],
                      acc_q[ex_pkg::XLEN-2:0], div_ge};

  assign quot = acc_q[ex_pkg::XLEN-1:0];
  assign rem  = acc_q[2*ex_pkg::XLEN-1:ex_pkg::XLEN];

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= MD_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        MD_IDLE: begin
          if (start_i) begin
            state_q <= MD_COMPUTE;
            cnt_q   <= '0;
          end
        end
        MD_COMPUTE: begin
          if (cnt_q == cnt_last) begin
            state_q <= MD_FINISH;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        // Done pulse, back to idle
        default: state_q <= MD_IDLE;
      endcase
    end
  end

  // Operand and accumulator registers
  always_ff @(posedge clk_i) begin
    if (state_q == MD_IDLE && start_i) begin
      op_q      <= op.md_operator;
      // Zero divisor keeps the quotient all ones
      neg_q     <= start_div ? ((a_neg ^ b_neg) & (|op.operand_b)) : (a_neg ^ b_neg);
      // Remainder takes the dividend sign
      neg_rem_q <= a_neg;
      acc_q     <= {{ex_pkg::XLEN{1'b0}}, start_div ? a_mag : b_mag};
      opd_q     <= start_div ? b_mag : a_mag;
    end else if (state_q == MD_COMPUTE) begin
      if (is_div && cnt_q == ex_pkg::MD_COUNT_W'(ex_pkg::XLEN)) begin
        // Quotient and remainder sign fix-up
        if (op_q == ex_pkg::MD_DIV) begin
          res_q <= neg_q ? (~quot + 1'b1) : quot;
        end else begin
          res_q <= neg_rem_q ? (~rem + 1'b1) : rem;
        end
      end else begin
        acc_q <= is_div ? div_next : mul_next;
      end
    end
  end

  ////////////////////////////////////////
  // Result
  ////////////////////////////////////////

  // Product sign from the operand signs
  assign prod_signed = neg_q ? (~acc_q + 1'b1) : acc_q;

  always_comb begin
    case (op_q)
      ex_pkg::MD_MUL:  result_o = prod_signed[ex_pkg::XLEN-1:0];
      ex_pkg::MD_MULH: result_o = prod_signed[2*ex_pkg::XLEN-1:ex_pkg::XLEN];
      default:         result_o = res_q;
    endcase
  end

  assign done_o = (state_q == MD_FINISH);

endmodule

//--- logic/ex_block.sv
// Execute block top level
`timescale 1ns/100ps

module ex_block (
  input  logic             clk_i,
  input  logic             rst_n_i,
  // Issue side
  input  logic             op_valid_i,
  input  logic             md_en_i,
  input  ex_pkg::alu_op_e  alu_operator_i,
  input  ex_pkg::md_op_e   md_operator_i,
  input  ex_pkg::md_sign_t md_signed_mode_i,
  input  ex_pkg::word_t    operand_a_i,
  input  ex_pkg::word_t    operand_b_i,
  output logic             ex_ready_o,
  // Result side
  output logic             result_valid_o,
  output ex_pkg::word_t    result_o,
  output logic             branch_decision_o,
  output ex_pkg::word_t    adder_result_o
);

  logic          accept;
  logic          busy_q;
  logic          start_q;
  logic          alu_valid_q;

  ex_pkg::word_t alu_result;
  ex_pkg::word_t alu_adder;
  logic          alu_branch;
  logic          md_done;
  ex_pkg::word_t md_result;

  ex_op_if op_if ();

  ////////////////////////////////////////
  // Issue
  ////////////////////////////////////////

  assign accept = op_valid_i & ex_ready_o;

  // Held until the next accept, stable for the divider
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_if.alu_operator   <= alu_operator_i;
      op_if.md_operator    <= md_operator_i;
      op_if.md_signed_mode <= md_signed_mode_i;
      op_if.operand_a      <= operand_a_i;
      op_if.operand_b      <= operand_b_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q      <= 1'b0;
      start_q     <= 1'b0;
      alu_valid_q <= 1'b0;
    end else begin
      // Start one cycle later, once the issue register holds the op
      start_q     <= accept & md_en_i;
      alu_valid_q <= accept & ~md_en_i;
      if (accept && md_en_i) begin
        busy_q <= 1'b1;
      end else if (md_done) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Ready again in the done cycle
  assign ex_ready_o = ~busy_q | md_done;

  ////////////////////////////////////////
  // Units
  ////////////////////////////////////////

  ex_alu alu0 (
    .op                ( op_if      ),
    .result_o          ( alu_result ),
    .adder_result_o    ( alu_adder  ),
    .branch_decision_o ( alu_branch )
  );

  ex_multdiv_slow md0 (
    .clk_i    ( clk_i     ),
    .rst_n_i  ( rst_n_i   ),
    .op       ( op_if     ),
    .start_i  ( start_q   ),
    .done_o   ( md_done   ),
    .result_o ( md_result )
  );

  // Result select
  // ALU and divider results never coincide, the divider blocks issue
  assign result_valid_o    = alu_valid_q | md_done;
  assign result_o          = md_done ? md_result : alu_result;
  assign branch_decision_o = alu_valid_q & alu_branch;
  assign adder_result_o    = alu_adder;

endmodule

//--- testbench/tb_clock_gen.sv
// Testbench clock and reset
`timescale 1ns/100ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // 4 ns period
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Reset held low for 16 cycles
  initial begin
    rst_n_o = 1'b0;
    repeat (16) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

//--- testbench/ex_block_props.sv
// Execute block handshake properties
`timescale 1ns/100ps

module ex_block_props (
  input logic clk_i,
  input logic rst_n_i,
  input logic op_valid_i,
  input logic md_en_i,
  input logic ex_ready_o,
  input logic result_valid_o
);

  // Consecutive cycles with ready low
  logic [6:0] low_cycles;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      low_cycles <= '0;
    end else if (ex_ready_o) begin
      low_cycles <= '0;
    end else begin
      low_cycles <= low_cycles + 7'd1;
    end
  end

  ////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////

  // ALU result one cycle after acceptance
  a_alu_result: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (op_valid_i && ex_ready_o && !md_en_i) |=> result_valid_o)
    else $error("ALU result did not follow its acceptance");

  a_ready_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    low_cycles <= 7'd40)
    else $error("ready held low for more than 40 cycles");

  // No issue while stalled, so no result shows up during a stall
  a_no_accept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (!ex_ready_o) |-> !result_valid_o)
    else $error("result appeared while ready was low");

endmodule

bind ex_block ex_block_props props0 (
  .clk_i          ( clk_i          ),
  .rst_n_i        ( rst_n_i        ),
  .op_valid_i     ( op_valid_i     ),
  .md_en_i        ( md_en_i        ),
  .ex_ready_o     ( ex_ready_o     ),
  .result_valid_o ( result_valid_o )
);

//--- testbench/ex_block_tb.sv
// Execute block testbench
`timescale 1ns/100ps

module ex_block_tb;

  // Operations per test, in order
  localparam int OP_COUNT = 40 + 96 + 48 + 144 + 160 + 38 + 24;
  // Worst case 40 cycles each, plus reset
  localparam int TIMEOUT_CYCLES = OP_COUNT * 40 + 16;
  localparam int STREAM_LEN = 24;

  logic             clk;
  logic             rst_n;
  logic             op_valid_i;
  logic             md_en_i;
  ex_pkg::alu_op_e  alu_operator_i;
  ex_pkg::md_op_e   md_operator_i;
  ex_pkg::md_sign_t md_signed_mode_i;
  ex_pkg::word_t    operand_a_i;
  ex_pkg::word_t    operand_b_i;
  logic             ex_ready_o;
  logic             result_valid_o;
  ex_pkg::word_t    result_o;
  logic             branch_decision_o;
  ex_pkg::word_t    adder_result_o;

  // Captured in the result cycle
  ex_pkg::word_t    got_result;
  ex_pkg::word_t    got_adder;
  logic             got_branch;

  logic [31:0]      rand_state = 32'h45d7_e650;
  int               cycle_count = 0;

  ex_pkg::word_t    edge_vals [4] = '{32'h0, 32'h1, 32'h8000_0000, 32'hffff_ffff};
  ex_pkg::alu_op_e  branch_ops [6] = '{ex_pkg::ALU_EQ, ex_pkg::ALU_NE, ex_pkg::ALU_LT,
                                       ex_pkg::ALU_GE, ex_pkg::ALU_LTU, ex_pkg::ALU_GEU};
  ex_pkg::alu_op_e  alu_ops [10] = '{ex_pkg::ALU_ADD, ex_pkg::ALU_SUB, ex_pkg::ALU_XOR,
                                     ex_pkg::ALU_OR, ex_pkg::ALU_AND, ex_pkg::ALU_SLL,
                                     ex_pkg::ALU_SRL, ex_pkg::ALU_SRA, ex_pkg::ALU_SLT,
                                     ex_pkg::ALU_SLTU};

  tb_clock_gen clk_gen0 (
    .clk_o   ( clk   ),
    .rst_n_o ( rst_n )
  );

  ex_block dut0 (
    .clk_i             ( clk               ),
    .rst_n_i           ( rst_n             ),
    .op_valid_i        ( op_valid_i        ),
    .md_en_i           ( md_en_i           ),
    .alu_operator_i    ( alu_operator_i    ),
    .md_operator_i     ( md_operator_i     ),
    .md_signed_mode_i  ( md_signed_mode_i  ),
    .operand_a_i       ( operand_a_i       ),
    .operand_b_i       ( operand_b_i       ),
    .ex_ready_o        ( ex_ready_o        ),
    .result_valid_o    ( result_valid_o    ),
    .result_o          ( result_o          ),
    .branch_decision_o ( branch_decision_o ),
    .adder_result_o    ( adder_result_o    )
  );

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // LCG step
  function automatic ex_pkg::word_t lcg_next();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  function automatic logic branch_model(ex_pkg::alu_op_e op, ex_pkg::word_t a,
                                        ex_pkg::word_t b);
    case (op)
      ex_pkg::ALU_EQ:  return a == b;
      ex_pkg::ALU_NE:  return a != b;
      ex_pkg::ALU_LT:  return $signed(a) < $signed(b);
      ex_pkg::ALU_GE:  return $signed(a) >= $signed(b);
      ex_pkg::ALU_LTU: return a < b;
      ex_pkg::ALU_GEU: return a >= b;
      default:         return 1'b0;
    endcase
  endfunction

  function automatic ex_pkg::word_t alu_model(ex_pkg::alu_op_e op, ex_pkg::word_t a,
                                              ex_pkg::word_t b);
    case (op)
      ex_pkg::ALU_ADD:  return a + b;
      ex_pkg::ALU_SUB:  return a - b;
      ex_pkg::ALU_XOR:  return a ^ b;
      ex_pkg::ALU_OR:   return a | b;
      ex_pkg::ALU_AND:  return a & b;
      ex_pkg::ALU_SLL:  return a << b[4:0];
      ex_pkg::ALU_SRL:  return a >> b[4:0];
      ex_pkg::ALU_SRA:  return ex_pkg::word_t'($signed(a) >>> b[4:0]);
      ex_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      ex_pkg::ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
      default:          return {31'd0, branch_model(op, a, b)};
    endcase
  endfunction

  function automatic ex_pkg::word_t md_model(ex_pkg::md_op_e op, ex_pkg::md_sign_t mode,
                                             ex_pkg::word_t a, ex_pkg::word_t b);
    logic [63:0] ea;
    logic [63:0] eb;
    logic [63:0] prod;
    longint      sa;
    longint      sb;
    ea = mode[0] ? {{32{a[31]}}, a} : {32'd0, a};
    eb = mode[1] ? {{32{b[31]}}, b} : {32'd0, b};
    prod = ea * eb;
    sa = $signed(ea);
    sb = $signed(eb);
    case (op)
      ex_pkg::MD_MUL:  return prod[31:0];
      ex_pkg::MD_MULH: return prod[63:32];
      default: begin
        // Division by zero
        if (b == 32'd0) begin
          return (op == ex_pkg::MD_DIV) ? 32'hffff_ffff : a;
        end
        // Signed overflow
        if (mode == 2'b11 && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
          return (op == ex_pkg::MD_DIV) ? a : 32'd0;
        end
        if (op == ex_pkg::MD_DIV) begin
          return ex_pkg::word_t'(sa / sb);
        end
        return ex_pkg::word_t'(sa % sb);
      end
    endcase
  endfunction

  task automatic check_value(input string name, input ex_pkg::word_t expected,
                             input ex_pkg::word_t actual);
    if (expected !== actual) begin
      $display("error %s: expected %h, actual %h", name, expected, actual);
      $display("TB FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // One operation, waits for ready and then for its result
  task automatic run_op(input logic md_en, input ex_pkg::alu_op_e aop,
                        input ex_pkg::md_op_e mop, input ex_pkg::md_sign_t mode,
                        input ex_pkg::word_t a, input ex_pkg::word_t b);
    @(posedge clk);
    op_valid_i       <= 1'b1;
    md_en_i          <= md_en;
    alu_operator_i   <= aop;
    md_operator_i    <= mop;
    md_signed_mode_i <= mode;
    operand_a_i      <= a;
    operand_b_i      <= b;
    @(negedge clk);
    while (!ex_ready_o) @(negedge clk);
    @(posedge clk);
    op_valid_i <= 1'b0;
    @(negedge clk);
    while (!result_valid_o) @(negedge clk);
    got_result = result_o;
    got_adder  = adder_result_o;
    got_branch = branch_decision_o;
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic test_arith();
    ex_pkg::word_t a;
    ex_pkg::word_t b;
    for (int op = 0; op < 5; op++) begin
      for (int i = 0; i < 8; i++) begin
        a = lcg_next();
        b = lcg_next();
        run_op(1'b0, alu_ops[op], ex_pkg::MD_MUL, 2'b00, a, b);
        check_value("arith result", alu_model(alu_ops[op], a, b), got_result);
        // Adder output is the jump target
        if (alu_ops[op] == ex_pkg::ALU_ADD) begin
          check_value("arith adder", a + b, got_adder);
        end else if (alu_ops[op] == ex_pkg::ALU_SUB) begin
          check_value("arith adder", a - b, got_adder);
        end
      end
    end
  endtask

  task automatic test_shift_compare();
    ex_pkg::word_t a;
    ex_pkg::word_t b;
    // Every shift amount, random upper bits in b
    for (int op = 5; op < 8; op++) begin
      for (int sh = 0; sh < 32; sh++) begin
        a = lcg_next();
        b = {lcg_next() & 32'hffff_ffe0} | sh;
        run_op(1'b0, alu_ops[op], ex_pkg::MD_MUL, 2'b00, a, b);
        check_value("shift", alu_model(alu_ops[op], a, b), got_result);
      end
    end
    // SLT and SLTU, boundary pairs then random
    for (int op = 8; op < 10; op++) begin
      for (int i = 0; i < 24; i++) begin
        a = (i < 16) ? edge_vals[i / 4] : lcg_next();
        b = (i < 16) ? edge_vals[i % 4] : lcg_next();
        run_op(1'b0, alu_ops[op], ex_pkg::MD_MUL, 2'b00, a, b);
        check_value("set less than", alu_model(alu_ops[op], a, b), got_result);
      end
    end
    // Branch compares
    for (int op = 0; op < 6; op++) begin
      for (int i = 0; i < 24; i++) begin
        a = (i < 16) ? edge_vals[i / 4] : lcg_next();
        b = (i < 16) ? edge_vals[i % 4] : lcg_next();
        run_op(1'b0, branch_ops[op], ex_pkg::MD_MUL, 2'b00, a, b);
        check_value("branch", {31'd0, branch_model(branch_ops[op], a, b)},
                    {31'd0, got_branch});
      end
    end
  endtask

  task automatic test_multiply();
    ex_pkg::word_t  a;
    ex_pkg::word_t  b;
    ex_pkg::md_op_e mop;
    for (int m = 0; m < 2; m++) begin
      mop = (m == 0) ? ex_pkg::MD_MUL : ex_pkg::MD_MULH;
      for (int mode = 0; mode < 4; mode++) begin
        for (int i = 0; i < 20; i++) begin
          a = (i < 16) ? edge_vals[i / 4] : lcg_next();
          b = (i < 16) ? edge_vals[i % 4] : lcg_next();
          run_op(1'b1, ex_pkg::ALU_ADD, mop, mode[1:0], a, b);
          check_value("multiply", md_model(mop, mode[1:0], a, b), got_result);
        end
      end
    end
  endtask

  task automatic test_divide();
    ex_pkg::word_t    a;
    ex_pkg::word_t    b;
    ex_pkg::md_op_e   mop;
    ex_pkg::md_sign_t mode;
    for (int m = 0; m < 2; m++) begin
      mop = (m == 0) ? ex_pkg::MD_DIV : ex_pkg::MD_REM;
      for (int s = 0; s < 2; s++) begin
        mode = (s == 0) ? 2'b00 : 2'b11;
        for (int i = 0; i < 8; i++) begin
          a = lcg_next();
          b = lcg_next() >> (i * 3);
          run_op(1'b1, ex_pkg::ALU_ADD, mop, mode, a, b);
          check_value("divide", md_model(mop, mode, a, b), got_result);
        end
        // Zero divisor
        a = lcg_next();
        run_op(1'b1, ex_pkg::ALU_ADD, mop, mode, a, 32'd0);
        check_value("divide by zero", md_model(mop, mode, a, 32'd0), got_result);
      end
      run_op(1'b1, ex_pkg::ALU_ADD, mop, 2'b11, 32'h8000_0000, 32'hffff_ffff);
      check_value("divide overflow", md_model(mop, 2'b11, 32'h8000_0000, 32'hffff_ffff),
                  got_result);
    end
  endtask

  // Valid held high, results collected in parallel
  task automatic test_stream();
    ex_pkg::word_t exp_q [$];
    ex_pkg::word_t exp_now;
    ex_pkg::word_t a;
    ex_pkg::word_t b;
    ex_pkg::alu_op_e aop;
    ex_pkg::md_op_e  mop;
    int received;
    received = 0;
    @(posedge clk);
    fork
      begin
        for (int i = 0; i < STREAM_LEN; i++) begin
          a   = lcg_next();
          b   = lcg_next();
          aop = alu_ops[lcg_next() % 32'd10];
          mop = ex_pkg::md_op_e'((i / 4) % 4);
          exp_now = (i % 4 == 3) ? md_model(mop, 2'b11, a, b) : alu_model(aop, a, b);
          op_valid_i       <= 1'b1;
          md_en_i          <= (i % 4 == 3);
          alu_operator_i   <= aop;
          md_operator_i    <= mop;
          md_signed_mode_i <= 2'b11;
          operand_a_i      <= a;
          operand_b_i      <= b;
          @(negedge clk);
          while (!ex_ready_o) @(negedge clk);
          @(posedge clk);
          exp_q.push_back(exp_now);
        end
        op_valid_i <= 1'b0;
      end
      begin
        while (received < STREAM_LEN) begin
          @(negedge clk);
          if (result_valid_o) begin
            if (exp_q.size() == 0) begin
              $display("stream produced a result with no operation issued");
              $display("TB FAILED");
              $fatal(1, "unexpected result");
            end
            check_value("stream result", exp_q.pop_front(), result_o);
            received++;
          end
        end
      end
    join
    // Longer than a divide, so a stray late result still gets counted
    repeat (40) begin
      @(negedge clk);
      if (result_valid_o) begin
        received++;
      end
    end
    check_value("stream result count", STREAM_LEN, received);
  endtask

  ////////////////////////////////////////
  // Timeout and main sequence
  ////////////////////////////////////////

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("timeout, the DUT stopped answering");
      $display("TB FAILED");
      $fatal(1, "timeout");
    end
  end

  initial begin
    op_valid_i       = 1'b0;
    md_en_i          = 1'b0;
    alu_operator_i   = ex_pkg::ALU_ADD;
    md_operator_i    = ex_pkg::MD_MUL;
    md_signed_mode_i = 2'b00;
    operand_a_i      = '0;
    operand_b_i      = '0;
    @(posedge rst_n);
    test_arith();
    test_shift_compare();
    test_multiply();
    test_divide();
    test_stream();
    $display("TB PASSED");
    $finish;
  end

endmodule

//--- ex_block.f
logic/ex_pkg.sv
logic/ex_op_if.sv
logic/ex_alu.sv
logic/ex_multdiv_slow.sv
logic/ex_block.sv
testbench/tb_clock_gen.sv
testbench/ex_block_props.sv
testbench/ex_block_tb.sv

//--- Makefile
SRCS := $(shell cat ex_block.f)

.PHONY: all run clean

all: run

obj_dir/Vex_block_tb: ex_block.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module ex_block_tb -f ex_block.f

run: obj_dir/Vex_block_tb
	./obj_dir/Vex_block_tb > sim.log 2>&1 || true
	cat sim.log
	@! grep -q "TB FAILED" sim.log
	@grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
